// ==== verilog/sheila_consts.svh ====
`ifndef SHEILA_CONSTS_SVH
`define SHEILA_CONSTS_SVH

// Upper address byte of the memory-mapped I/O page (FE00 to FEFF)
`define SHEILA_PAGE 8'hFE

// Mock peripheral blocks behind the page
// CRTC, ACIA, VIA, user VIA, FDC, ADC and Tube
`define NUM_SLOTS 7

// Register index width inside one block
// Sixteen registers each, aliased across the window
`define REG_ADDR_W 4

// Processor data bus width
`define DATA_W 8

// Byte returned when nothing in the page drives the bus
`define UNMAPPED_DATA 8'hFF

`endif

// ==== verilog/sheilaPkg.sv ====
`include "sheila_consts.svh"

package sheilaPkg;

	// Full 6502 address
	typedef logic [15:0] busAddrT;

	// One byte on the data bus
	typedef logic [`DATA_W-1:0] busDataT;

	// Register index as seen by a peripheral block
	typedef logic [`REG_ADDR_W-1:0] regAddrT;

	// One bit per peripheral slot
	// Bit k belongs to slot k in the window table
	typedef logic [`NUM_SLOTS-1:0] slotVecT;

	// Paged ROM bank number held by ROMSEL
	typedef logic [3:0] romBankT;

endpackage

// ==== verilog/sheilaDecoder.sv ====
`timescale 1ns/100ps

`include "sheila_consts.svh"

module sheilaDecoder (
	input logic clk2MHz,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input sheilaPkg::busAddrT adr,
	input sheilaPkg::busDataT datWr,
	input logic ack,
	output sheilaPkg::slotVecT slotStb,
	output logic localAck,
	output sheilaPkg::romBankT romBank
);

	import sheilaPkg::*;

	logic pageHit;
	logic [7:0] pageOffset;
	slotVecT winMatch;
	slotVecT slotHit;
	logic romselHit;
	logic noSlotHit;
	logic cycleStart;
	logic localClaim;

	// Address is inside FE00..FEFF
	assign pageHit = (adr[15:8] == `SHEILA_PAGE);
	assign pageOffset = adr[7:0];

	// A new access is only taken once the previous ack has gone
	// This keeps ack to a single cycle while stb is held
	assign cycleStart = cyc & stb & ~ack;

	// Window match by offset inside the page
	always_comb begin
		winMatch = '0;
		// CRTC 00-07
		winMatch[0] = (pageOffset[7:3] == 5'b00000);
		// ACIA 08-0F
		winMatch[1] = (pageOffset[7:3] == 5'b00001);
		// System VIA 40-5F
		winMatch[2] = (pageOffset[7:5] == 3'b010);
		// User VIA 60-7F
		winMatch[3] = (pageOffset[7:5] == 3'b011);
		// FDC 80-9F
		winMatch[4] = (pageOffset[7:5] == 3'b100);
		// ADC C0-DF
		winMatch[5] = (pageOffset[7:5] == 3'b110);
		// Tube E0-FF
		winMatch[6] = (pageOffset[7:5] == 3'b111);
	end

	// Windows only count when the page itself is selected
	assign slotHit = pageHit ? winMatch : '0;

	// ROMSEL at 30-3F, the bank latch lives here
	assign romselHit = pageHit & (pageOffset[7:4] == 4'b0011);

	// VIDPROC 20-2F falls through as unmapped, as do 10-1F and A0-BF
	assign noSlotHit = ~|slotHit;

	// Decoder answers itself for ROMSEL and anything unclaimed
	assign localClaim = romselHit | noSlotHit;

	// One-hot strobes to the peripheral blocks
	assign slotStb = {`NUM_SLOTS{cycleStart}} & slotHit;

	// Local acknowledge, one cycle after the strobe
	always_ff @(posedge clk2MHz) begin
		if (rst) begin
			localAck <= 1'b0;
		end else begin
			localAck <= cycleStart & localClaim;
		end
	end

	// Paged ROM bank latch
	// Only writes load it, reads of ROMSEL leave it alone
	always_ff @(posedge clk2MHz) begin
		if (rst) begin
			romBank <= '0;
		end else if (cycleStart && we && romselHit) begin
			romBank <= romBankT'(datWr[3:0]);
		end
	end

endmodule

// ==== verilog/mockPeripheral.sv ====
`timescale 1ns/100ps

`include "sheila_consts.svh"

module mockPeripheral (
	input logic clk2MHz,
	input logic rst,
	input logic stbIn,
	input logic we,
	input sheilaPkg::regAddrT regAddr,
	input sheilaPkg::busDataT datWr,
	output logic ackOut,
	output sheilaPkg::busDataT datOut
);

	import sheilaPkg::*;

	localparam int numRegs = 1 << `REG_ADDR_W;

	// Register file standing in for the real chip
	busDataT regFile [0:numRegs-1];

	// Acknowledge follows the strobe by one cycle
	// The decoder drops the strobe while ack is up
	always_ff @(posedge clk2MHz) begin
		if (rst) begin
			ackOut <= 1'b0;
		end else begin
			ackOut <= stbIn;
		end
	end

	// Writes land on the same edge that raises the ack
	always_ff @(posedge clk2MHz) begin
		if (rst) begin
			for (int i = 0; i < numRegs; i++) begin
				regFile[i] <= '0;
			end
		end else if (stbIn && we) begin
			regFile[regAddr] <= datWr;
		end
	end

	// Read byte captured alongside the ack
	// A write cycle echoes the byte just written
	always_ff @(posedge clk2MHz) begin
		if (stbIn) begin
			if (we) begin
				datOut <= datWr;
			end else begin
				datOut <= regFile[regAddr];
			end
		end
	end

endmodule

// ==== verilog/readReturnMux.sv ====
`timescale 1ns/100ps

`include "sheila_consts.svh"

module readReturnMux (
	input sheilaPkg::slotVecT slotAck,
	input sheilaPkg::busDataT slotDat [0:`NUM_SLOTS-1],
	input logic localAck,
	output logic ack,
	output sheilaPkg::busDataT datRd
);

	import sheilaPkg::*;

	busDataT selData;
	logic anySlotAck;

	// At most one responder per cycle since only one access is in flight
	assign anySlotAck = |slotAck;

	// Bus acknowledge from any block or from the decoder
	assign ack = anySlotAck | localAck;

	// Pick the data of whichever slot answered
	// Falls back to the unmapped byte when only the decoder answers
	always_comb begin
		selData = busDataT'(`UNMAPPED_DATA);
		for (int k = 0; k < `NUM_SLOTS; k++) begin
			if (slotAck[k]) begin
				selData = slotDat[k];
			end
		end
	end

	assign datRd = selData;

endmodule

// ==== verilog/sheilaBus.sv ====
`timescale 1ns/100ps

`include "sheila_consts.svh"

module sheilaBus (
	input logic clk2MHz,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input sheilaPkg::busAddrT adr,
	input sheilaPkg::busDataT datWr,
	output logic ack,
	output sheilaPkg::busDataT datRd,
	output sheilaPkg::romBankT romBank
);

	import sheilaPkg::*;

	slotVecT slotStb;
	slotVecT slotAck;
	busDataT slotDat [0:`NUM_SLOTS-1];
	logic localAck;
	regAddrT regAddr;

	// Every block sees the low address bits so registers alias per 16 bytes
	assign regAddr = adr[`REG_ADDR_W-1:0];

	// Page decode and ROMSEL latch
	sheilaDecoder decoder_i (
		.clk2MHz (clk2MHz),
		.rst (rst),
		.cyc (cyc),
		.stb (stb),
		.we (we),
		.adr (adr),
		.datWr (datWr),
		.ack (ack),
		.slotStb (slotStb),
		.localAck (localAck),
		.romBank (romBank)
	);

	// Mock CRTC, ACIA, VIA, user VIA, FDC, ADC and Tube in slot order
	for (genvar k = 0; k < `NUM_SLOTS; k++) begin : genSlot
		mockPeripheral periph_i (
			.clk2MHz (clk2MHz),
			.rst (rst),
			.stbIn (slotStb[k]),
			.we (we),
			.regAddr (regAddr),
			.datWr (datWr),
			.ackOut (slotAck[k]),
			.datOut (slotDat[k])
		);
	end

	// Merge replies back onto the bus
	readReturnMux mux_i (
		.slotAck (slotAck),
		.slotDat (slotDat),
		.localAck (localAck),
		.ack (ack),
		.datRd (datRd)
	);

endmodule

// ==== tb/sheilaBusTb.sv ====
`timescale 1ns/100ps

module sheilaBusTb;

	localparam int maxRows = 128;

	logic clk2MHz;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	logic [15:0] adr;
	logic [7:0] datWr;
	logic ack;
	logic [7:0] datRd;
	logic [3:0] romBank;

	// Stimulus table with expected columns filled in from the model
	logic rowWe [0:maxRows-1];
	logic [15:0] rowAdr [0:maxRows-1];
	logic [7:0] rowDat [0:maxRows-1];
	logic [7:0] rowExpRd [0:maxRows-1];
	logic [3:0] rowExpBank [0:maxRows-1];
	int numRows;

	// Reference model of the seven register blocks and the bank latch
	logic [7:0] model [0:6][0:15];
	logic [3:0] modelBank;

	integer seed;
	int cycleCount;
	int cycleLimit;
	int passCount;
	int failCount;

	sheilaBus dut_i (
		.clk2MHz (clk2MHz),
		.rst (rst),
		.cyc (cyc),
		.stb (stb),
		.we (we),
		.adr (adr),
		.datWr (datWr),
		.ack (ack),
		.datRd (datRd),
		.romBank (romBank)
	);

	always #10 clk2MHz = ~clk2MHz;

	always @(posedge clk2MHz) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("timeout, run stopped after %0d cycles", cycleCount);
			$display("test failed");
			$finish;
		end
	end

	// Slot number for an address in the I/O page
	// Returns -1 when nothing claims the address
	function automatic int slotOf(input logic [15:0] a);
		logic [7:0] off;
		off = a[7:0];
		if (a[15:8] != 8'hFE) return -1;
		if (off <= 8'h07) return 0;
		if (off <= 8'h0F) return 1;
		if (off >= 8'h40 && off <= 8'h5F) return 2;
		if (off >= 8'h60 && off <= 8'h7F) return 3;
		if (off >= 8'h80 && off <= 8'h9F) return 4;
		if (off >= 8'hC0 && off <= 8'hDF) return 5;
		if (off >= 8'hE0) return 6;
		return -1;
	endfunction

	function automatic logic isRomsel(input logic [15:0] a);
		return (a[15:8] == 8'hFE) && (a[7:0] >= 8'h30) && (a[7:0] <= 8'h3F);
	endfunction

	// First offset of each slot's window
	function automatic logic [7:0] baseOf(input int k);
		case (k)
			0: return 8'h00;
			1: return 8'h08;
			2: return 8'h40;
			3: return 8'h60;
			4: return 8'h80;
			5: return 8'hC0;
			6: return 8'hE0;
			default: return 8'h00;
		endcase
	endfunction

	function automatic logic [7:0] nextByte();
		integer rnd;
		rnd = $random(seed);
		return rnd[7:0];
	endfunction

	task automatic addWrite(input logic [15:0] a, input logic [7:0] d);
		int s;
		s = slotOf(a);
		// Registers alias every 16 bytes
		if (s >= 0) model[s][a[3:0]] = d;
		if (isRomsel(a)) modelBank = d[3:0];
		rowWe[numRows] = 1'b1;
		rowAdr[numRows] = a;
		rowDat[numRows] = d;
		rowExpRd[numRows] = 8'h00;
		rowExpBank[numRows] = modelBank;
		numRows++;
	endtask

	task automatic addRead(input logic [15:0] a);
		int s;
		s = slotOf(a);
		rowWe[numRows] = 1'b0;
		rowAdr[numRows] = a;
		rowDat[numRows] = 8'h00;
		rowExpRd[numRows] = (s >= 0) ? model[s][a[3:0]] : 8'hFF;
		rowExpBank[numRows] = modelBank;
		numRows++;
	endtask

	task automatic addAlias(input logic [7:0] off);
		addWrite({8'hFE, off}, nextByte());
		addRead({8'hFE, off + 8'h10});
	endtask

	task automatic buildTable();
		// Reset values in every slot
		for (int k = 0; k < 7; k++) begin
			addRead({8'hFE, baseOf(k) + 8'h03});
		end
		// Write and read back, then check the written index in the next slot
		// ACIA cannot reach index 6 so the CRTC write is followed by its index E
		for (int k = 0; k < 7; k++) begin
			addWrite({8'hFE, baseOf(k) + 8'h06}, nextByte());
			addRead({8'hFE, baseOf(k) + 8'h06});
			addRead({8'hFE, baseOf((k + 1) % 7) | ((baseOf(k) + 8'h06) & 8'h0F)});
		end
		addAlias(8'h41);
		addAlias(8'h63);
		addAlias(8'h85);
		addAlias(8'hC3);
		addAlias(8'hE5);
		// ROMSEL is write-only
		// Bank nibbles differ from each other and from the reset value
		addWrite(16'hFE30, (nextByte() & 8'hF0) | 8'h05);
		addWrite(16'hFE3F, (nextByte() & 8'hF0) | 8'h0A);
		addRead(16'hFE30);
		addRead(16'hFE3F);
		addRead(16'hFE18);
		addRead(16'hFE2F);
		addRead(16'hFEA5);
		addRead(16'h8000);
		addWrite(16'hFE18, nextByte());
		addWrite(16'hFE2F, nextByte());
		addWrite(16'hFEA5, nextByte());
		addWrite(16'h8030, nextByte());
		addWrite(16'h8005, nextByte());
		// Indexes those writes would alias onto if they leaked
		addRead(16'hFE08);
		addRead(16'hFE0F);
		addRead(16'hFE45);
		addRead(16'hFEC5);
		addRead(16'hFE05);
	endtask

	// One Wishbone classic access
	// Inputs change on falling edges only
	task automatic busAccess(input logic w, input logic [15:0] a, input logic [7:0] d,
			output logic gotAck, output int latency, output logic [7:0] rd,
			output logic [3:0] bank);
		gotAck = 1'b0;
		latency = 0;
		rd = 8'h00;
		bank = 4'h0;
		@(negedge clk2MHz);
		cyc = 1'b1;
		stb = 1'b1;
		we = w;
		adr = a;
		datWr = d;
		while (!gotAck && latency < 4) begin
			@(negedge clk2MHz);
			latency++;
			if (ack === 1'b1) begin
				gotAck = 1'b1;
				rd = datRd;
				bank = romBank;
			end
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic recordResult(input string name, input int errs);
		if (errs == 0) begin
			$display("%s: ok", name);
			passCount++;
		end else begin
			$display("%s: FAILED with %0d errors", name, errs);
			failCount++;
		end
	endtask

	task automatic runRow(input int r);
		logic gotAck;
		int latency;
		logic [7:0] rd;
		logic [3:0] bank;
		int errs;
		errs = 0;
		busAccess(rowWe[r], rowAdr[r], rowDat[r], gotAck, latency, rd, bank);
		if (!gotAck) begin
			$display("row %0d: no acknowledge within 4 cycles at address %h", r, rowAdr[r]);
			errs++;
		end else begin
			if (latency != 1) begin
				$display("row %0d: acknowledge came %0d cycles after the strobe, not 1",
					r, latency);
				errs++;
			end
			if (!rowWe[r] && rd !== rowExpRd[r]) begin
				$display("ERROR row %0d: datRd expected 0x%h got 0x%h", r, rowExpRd[r], rd);
				errs++;
			end
			if (bank !== rowExpBank[r]) begin
				$display("ERROR row %0d: romBank expected 0x%h got 0x%h", r, rowExpBank[r], bank);
				errs++;
			end
			// Ack must be gone one cycle later
			@(negedge clk2MHz);
			if (ack !== 1'b0) begin
				$display("row %0d: acknowledge stayed high for more than one cycle", r);
				errs++;
			end
		end
		recordResult($sformatf("row %0d %s %h", r, rowWe[r] ? "write" : "read", rowAdr[r]), errs);
	endtask

	// Strobe held past the ack
	// Acks must alternate with a gap between
	task automatic heldStrobe();
		logic [7:0] d;
		logic gotAck;
		int latency;
		logic [7:0] rd;
		logic [3:0] bank;
		logic expAck;
		int errs;
		errs = 0;
		d = nextByte();
		@(negedge clk2MHz);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = 16'hFE62;
		datWr = d;
		for (int i = 0; i < 4; i++) begin
			@(negedge clk2MHz);
			expAck = (i % 2 == 0);
			if (ack !== expAck) begin
				$display("ERROR held stb cycle %0d: ack expected 0x%h got 0x%h", i, expAck, ack);
				errs++;
			end
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		model[3][2] = d;
		busAccess(1'b0, 16'hFE62, 8'h00, gotAck, latency, rd, bank);
		if (!gotAck) begin
			$display("held stb read-back: no acknowledge within 4 cycles");
			errs++;
		end else if (rd !== model[3][2]) begin
			$display("ERROR held stb read-back: datRd expected 0x%h got 0x%h", model[3][2], rd);
			errs++;
		end
		recordResult("held stb write and read-back", errs);
	endtask

	initial begin
		clk2MHz = 1'b0;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 16'h0000;
		datWr = 8'h00;
		seed = 32'h1009;
		numRows = 0;
		cycleCount = 0;
		cycleLimit = 50;
		passCount = 0;
		failCount = 0;
		modelBank = 4'h0;
		for (int k = 0; k < 7; k++) begin
			for (int i = 0; i < 16; i++) begin
				model[k][i] = 8'h00;
			end
		end
		buildTable();
		cycleLimit = numRows * 6 + 50;
		repeat (2) @(negedge clk2MHz);
		rst = 1'b0;
		for (int r = 0; r < numRows; r++) begin
			runRow(r);
		end
		heldStrobe();
		$display("%0d tests run, %0d passed, %0d failed", passCount + failCount,
			passCount, failCount);
		if (failCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/sheilaPkg.sv
verilog/sheilaDecoder.sv
verilog/mockPeripheral.sv
verilog/readReturnMux.sv
verilog/sheilaBus.sv
tb/sheilaBusTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SHEILA page testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
	--top-module sheilaBusTb \
	-f files.f \
	--Mdir obj_dir \
	-o simTb

./obj_dir/simTb | tee sim.log

if grep -q "test failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation finished without failures"
